//--- include/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// logical banks built as single-port RAMs
`define NUM_BANKS 4
`define BANK_BITS 2

// rows per bank and depth of the spare and the map
`define NUM_ROWS 16
`define ROW_BITS 4

// data word
`define DATA_WIDTH 16

// logical address holds the row above the bank
`define ADDR_BITS (`ROW_BITS + `BANK_BITS)

// physical bank index has one extra bit
// so that the spare sits at index NUM_BANKS
`define PBANK_BITS (`BANK_BITS + 1)

`endif

//--- rtl/mem_pkg.sv
`include "mem_settings.svh"

package mem_pkg;

  typedef logic [`BANK_BITS-1:0]  bank_t;
  typedef logic [`ROW_BITS-1:0]   row_t;
  typedef logic [`DATA_WIDTH-1:0] data_t;
  typedef logic [`ADDR_BITS-1:0]  addr_t;
  typedef logic [`PBANK_BITS-1:0] pbank_t;

  // which bank's copy of this row the spare currently holds
  typedef struct packed {
    logic  vld;
    bank_t bank;
  } map_entry_t;

  typedef struct packed {
    addr_t adr;
    data_t din;
  } wr_req_t;

  // physical location of a read
  typedef struct packed {
    pbank_t bank;
    row_t   row;
  } padr_t;

  typedef struct packed {
    data_t dout;
    padr_t padr;
  } rd_rsp_t;

  function automatic bank_t adr_bank(addr_t adr);
    return adr[`BANK_BITS-1:0];
  endfunction

  function automatic row_t adr_row(addr_t adr);
    return adr[`ADDR_BITS-1:`BANK_BITS];
  endfunction

endpackage

//--- rtl/bank_ram.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

// one logical bank with one access per cycle
module bank_ram
  import mem_pkg::*;
(
  input  logic  clk,
  input  logic  en,
  input  logic  we,
  input  row_t  row,
  input  data_t din,
  output data_t dout
);

  data_t mem [`NUM_ROWS];

  // either a write or a read in one cycle
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[row] <= din;
      end else begin
        // read data held until the next read
        dout <= mem[row];
      end
    end
  end

endmodule

//--- rtl/spare_ram.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

// spare bank with one row per logical row
module spare_ram
  import mem_pkg::*;
(
  input  logic  clk,
  input  row_t  rd_row,
  output data_t rd_data,
  input  row_t  ev_row,
  output data_t ev_data,
  input  logic  we,
  input  row_t  wr_row,
  input  data_t din
);

  data_t mem [`NUM_ROWS];

  // read port for the user read
  assign rd_data = mem[rd_row];

  // old contents that eviction moves back to the home bank
  assign ev_data = mem[ev_row];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_row] <= din;
    end
  end

endmodule

//--- rtl/map_table.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

// per-row record of what the spare holds
module map_table
  import mem_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  row_t       rd_row,
  input  row_t       wr_row,
  output map_entry_t rd_entry,
  output map_entry_t wr_entry,
  input  logic       upd_en,
  input  row_t       upd_row,
  input  map_entry_t upd_entry,
  output logic       ready
);

  map_entry_t entries [`NUM_ROWS];
  row_t       sweep_row;

  // lookups see the state before this cycle's update
  assign rd_entry = entries[rd_row];
  assign wr_entry = entries[wr_row];

  // clearing sweep over one row per cycle after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      sweep_row <= '0;
      ready     <= 1'b0;
    end else if (!ready) begin
      sweep_row <= sweep_row + row_t'(1);
      if (sweep_row == row_t'(`NUM_ROWS - 1)) begin
        ready <= 1'b1;
      end
    end
  end

  // sweep owns the write port until ready
  always_ff @(posedge clk) begin
    if (!ready) begin
      entries[sweep_row] <= '0;
    end else if (upd_en) begin
      entries[upd_row] <= upd_entry;
    end
  end

endmodule

//--- rtl/remap_ctrl.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

// routes the read and write of each cycle over the banks and the spare
module remap_ctrl
  import mem_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       ready,
  input  logic       read,
  input  addr_t      rd_adr,
  input  logic       write,
  input  wr_req_t    wr,
  output row_t       rd_row,
  output row_t       wr_row,
  input  map_entry_t rd_entry,
  input  map_entry_t wr_entry,
  output logic       upd_en,
  output row_t       upd_row,
  output map_entry_t upd_entry,
  output logic       bank_en [`NUM_BANKS],
  output logic       bank_we [`NUM_BANKS],
  output row_t       bank_row [`NUM_BANKS],
  output data_t      bank_din [`NUM_BANKS],
  input  data_t      bank_dout [`NUM_BANKS],
  input  data_t      spare_rd_data,
  input  data_t      spare_ev_data,
  output logic       spare_we,
  output logic       rd_vld,
  output rd_rsp_t    rd
);

  logic  rd_acc;
  logic  wr_acc;
  bank_t rd_bank;
  bank_t wr_bank;
  logic  collide;
  logic  rd_from_spare;
  logic  evict;
  logic  src_spare_q;
  data_t spare_q;
  padr_t padr_q;

  assign rd_acc  = read && ready;
  assign wr_acc  = write && ready;
  assign rd_bank = adr_bank(rd_adr);
  assign rd_row  = adr_row(rd_adr);
  assign wr_bank = adr_bank(wr.adr);
  assign wr_row  = adr_row(wr.adr);

  // write and read want the same single-port bank
  assign collide = rd_acc && wr_acc && (rd_bank == wr_bank);

  // spare holds the newest copy of the read location
  assign rd_from_spare = rd_entry.vld && (rd_entry.bank == rd_bank);

  // spare row of another bank goes back home first
  assign evict = collide && wr_entry.vld && (wr_entry.bank != wr_bank);

  assign spare_we = collide;
  assign upd_row  = wr_row;

  always_comb begin
    upd_en    = 1'b0;
    upd_entry = '0;
    if (collide) begin
      upd_en    = 1'b1;
      upd_entry = '{vld: 1'b1, bank: wr_bank};
    end else if (wr_acc && wr_entry.vld && (wr_entry.bank == wr_bank)) begin
      // home bank now holds the newer copy
      upd_en = 1'b1;
    end
  end

  // at most one of read, write or eviction per bank
  always_comb begin
    for (int i = 0; i < `NUM_BANKS; i++) begin
      bank_en[i]  = 1'b0;
      bank_we[i]  = 1'b0;
      bank_row[i] = wr_row;
      bank_din[i] = wr.din;
      if (rd_acc && !rd_from_spare && (rd_bank == bank_t'(i))) begin
        bank_en[i]  = 1'b1;
        bank_row[i] = rd_row;
      end else if (wr_acc && !collide && (wr_bank == bank_t'(i))) begin
        bank_en[i] = 1'b1;
        bank_we[i] = 1'b1;
      end else if (evict && (wr_entry.bank == bank_t'(i))) begin
        bank_en[i]  = 1'b1;
        bank_we[i]  = 1'b1;
        bank_din[i] = spare_ev_data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= rd_acc;
    end
  end

  // the combinational spare read is delayed to match the banks
  always_ff @(posedge clk) begin
    if (rd_acc) begin
      src_spare_q <= rd_from_spare;
      spare_q     <= spare_rd_data;
      padr_q.row  <= rd_row;
      padr_q.bank <= rd_from_spare ? pbank_t'(`NUM_BANKS) : pbank_t'(rd_bank);
    end
  end

  assign rd.dout = src_spare_q ? spare_q : bank_dout[padr_q.bank[`BANK_BITS-1:0]];
  assign rd.padr = padr_q;

endmodule

//--- rtl/mem_1r1w_top.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

// one read and one write per cycle over single-port banks
module mem_1r1w_top
  import mem_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    read,
  input  addr_t   rd_adr,
  input  logic    write,
  input  wr_req_t wr,
  output logic    ready,
  output logic    rd_vld,
  output rd_rsp_t rd
);

  row_t       rd_row;
  row_t       wr_row;
  map_entry_t rd_entry;
  map_entry_t wr_entry;
  logic       upd_en;
  row_t       upd_row;
  map_entry_t upd_entry;
  logic       bank_en [`NUM_BANKS];
  logic       bank_we [`NUM_BANKS];
  row_t       bank_row [`NUM_BANKS];
  data_t      bank_din [`NUM_BANKS];
  data_t      bank_dout [`NUM_BANKS];
  data_t      spare_rd_data;
  data_t      spare_ev_data;
  logic       spare_we;

  map_table map_table_inst (
    .clk       (clk),
    .rst       (rst),
    .rd_row    (rd_row),
    .wr_row    (wr_row),
    .rd_entry  (rd_entry),
    .wr_entry  (wr_entry),
    .upd_en    (upd_en),
    .upd_row   (upd_row),
    .upd_entry (upd_entry),
    .ready     (ready)
  );

  // eviction and new write both use the write row
  spare_ram spare_ram_inst (
    .clk     (clk),
    .rd_row  (rd_row),
    .rd_data (spare_rd_data),
    .ev_row  (wr_row),
    .ev_data (spare_ev_data),
    .we      (spare_we),
    .wr_row  (wr_row),
    .din     (wr.din)
  );

  for (genvar g = 0; g < `NUM_BANKS; g++) begin : gen_bank
    bank_ram bank_ram_inst (
      .clk  (clk),
      .en   (bank_en[g]),
      .we   (bank_we[g]),
      .row  (bank_row[g]),
      .din  (bank_din[g]),
      .dout (bank_dout[g])
    );
  end

  remap_ctrl remap_ctrl_inst (
    .clk           (clk),
    .rst           (rst),
    .ready         (ready),
    .read          (read),
    .rd_adr        (rd_adr),
    .write         (write),
    .wr            (wr),
    .rd_row        (rd_row),
    .wr_row        (wr_row),
    .rd_entry      (rd_entry),
    .wr_entry      (wr_entry),
    .upd_en        (upd_en),
    .upd_row       (upd_row),
    .upd_entry     (upd_entry),
    .bank_en       (bank_en),
    .bank_we       (bank_we),
    .bank_row      (bank_row),
    .bank_din      (bank_din),
    .bank_dout     (bank_dout),
    .spare_rd_data (spare_rd_data),
    .spare_ev_data (spare_ev_data),
    .spare_we      (spare_we),
    .rd_vld        (rd_vld),
    .rd            (rd)
  );

endmodule

//--- verification/tb_mem_1r1w.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module tb_mem_1r1w
  import mem_pkg::*;
;

  localparam int N_PAIRS = 16;
  localparam int N_COLL = 8;
  localparam int N_RAND = 400;
  localparam int N_SAME = 8;
  localparam int N_B2B = 16;
  // reset, sweep, all test steps and one idle step after each test
  localparam int TOTAL_CYCLES = 4 + `NUM_ROWS + 2 * N_PAIRS + 2 * N_COLL + N_RAND
                                + 3 * N_SAME + N_B2B + 5;

  logic    clk;
  logic    rst;
  logic    read;
  addr_t   rd_adr;
  logic    write;
  wr_req_t wr;
  logic    ready;
  logic    rd_vld;
  rd_rsp_t rd;

  integer seed;
  int     checks;
  int     errors;
  int     err_start;
  int     test_num;
  int     ev_count;

  // logical contents and a mirror of the map for the reference model
  data_t      mdata [2**`ADDR_BITS];
  logic       mwritten [2**`ADDR_BITS];
  map_entry_t mmap [`NUM_ROWS];

  // expected result of the read accepted at the next edge
  logic   exp_vld;
  logic   exp_known;
  data_t  exp_dout;
  pbank_t exp_bank;
  row_t   exp_row;

  mem_1r1w_top mem_1r1w_top_inst (
    .clk    (clk),
    .rst    (rst),
    .read   (read),
    .rd_adr (rd_adr),
    .write  (write),
    .wr     (wr),
    .ready  (ready),
    .rd_vld (rd_vld),
    .rd     (rd)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #(TOTAL_CYCLES * 8 + 200);
    $display("timeout: the tests did not finish in the expected time");
    $display("Done: errors found");
    $finish;
  end

  task automatic check_data(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      $display("FAIL %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_padr(input string name, input pbank_t got_bank, input row_t got_row,
                            input pbank_t exp_bank_v, input row_t exp_row_v);
    checks++;
    if (got_bank !== exp_bank_v || got_row !== exp_row_v) begin
      $display("FAIL %s: got bank %h row %h, expected bank %h row %h",
               name, got_bank, got_row, exp_bank_v, exp_row_v);
      errors++;
    end
  endtask

  task automatic check_vld(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("FAIL %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // routing rules 1 to 4 with the read side decided on the old map
  function automatic void apply_model(input logic rd_en, input addr_t ra, input logic wr_en,
                                      input addr_t wa, input data_t wd);
    bank_t rb;
    row_t  rr;
    bank_t wb;
    row_t  wrow;
    rb = ra[`BANK_BITS-1:0];
    rr = ra[`ADDR_BITS-1:`BANK_BITS];
    wb = wa[`BANK_BITS-1:0];
    wrow = wa[`ADDR_BITS-1:`BANK_BITS];
    exp_vld = rd_en;
    exp_known = rd_en && mwritten[ra];
    exp_dout = mdata[ra];
    exp_row = rr;
    if (mmap[rr].vld && mmap[rr].bank == rb) begin
      exp_bank = pbank_t'(`NUM_BANKS);
    end else begin
      exp_bank = pbank_t'(rb);
    end
    if (wr_en) begin
      if (rd_en && rb == wb) begin
        if (mmap[wrow].vld && mmap[wrow].bank != wb) begin
          ev_count++;
        end
        mmap[wrow].vld = 1'b1;
        mmap[wrow].bank = wb;
      end else if (mmap[wrow].vld && mmap[wrow].bank == wb) begin
        mmap[wrow].vld = 1'b0;
      end
      mdata[wa] = wd;
      mwritten[wa] = 1'b1;
    end
  endfunction

  // drive one cycle and check the read accepted at this edge
  task automatic step(input logic rd_en, input addr_t ra, input logic wr_en, input addr_t wa,
                      input data_t wd);
    @(posedge clk);
    read   <= rd_en;
    rd_adr <= ra;
    write  <= wr_en;
    wr.adr <= wa;
    wr.din <= wd;
    @(negedge clk);
    check_vld("ready", ready, 1'b1);
    check_vld("rd_vld", rd_vld, exp_vld);
    if (exp_vld) begin
      if (exp_known) begin
        check_data("rd.dout", rd.dout, exp_dout);
      end
      check_padr("rd.padr", rd.padr.bank, rd.padr.row, exp_bank, exp_row);
    end
    apply_model(rd_en, ra, wr_en, wa, wd);
  endtask

  task automatic idle();
    step(1'b0, '0, 1'b0, '0, '0);
  endtask

  task automatic end_test(input string name);
    test_num++;
    $display("test %0d %s: %0d errors", test_num, name, errors - err_start);
    err_start = errors;
  endtask

  initial begin
    addr_t ra;
    addr_t wa;
    data_t wd;
    seed = 32'h0956_992c;
    checks = 0;
    errors = 0;
    err_start = 0;
    test_num = 0;
    ev_count = 0;
    exp_vld = 1'b0;
    exp_known = 1'b0;
    exp_dout = '0;
    exp_bank = '0;
    exp_row = '0;
    for (int i = 0; i < 2**`ADDR_BITS; i++) begin
      mdata[i] = '0;
      mwritten[i] = 1'b0;
    end
    for (int i = 0; i < `NUM_ROWS; i++) begin
      mmap[i] = '0;
    end
    rst    <= 1'b1;
    read   <= 1'b0;
    rd_adr <= '0;
    write  <= 1'b0;
    wr     <= '0;

    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      if (i == 3) begin
        rst <= 1'b0;
      end
      @(negedge clk);
      check_vld("ready", ready, 1'b0);
      check_vld("rd_vld", rd_vld, 1'b0);
    end
    // requests during the sweep must be ignored
    for (int i = 1; i <= `NUM_ROWS; i++) begin
      @(posedge clk);
      read   <= (i < `NUM_ROWS);
      write  <= (i < `NUM_ROWS);
      rd_adr <= addr_t'($random(seed));
      wr.adr <= addr_t'($random(seed));
      wr.din <= data_t'($random(seed));
      @(negedge clk);
      check_vld("ready", ready, i == `NUM_ROWS);
      check_vld("rd_vld", rd_vld, 1'b0);
    end
    end_test("reset and sweep");

    for (int i = 0; i < N_PAIRS; i++) begin
      wa = addr_t'($random(seed));
      wd = data_t'($random(seed));
      ra = {row_t'($random(seed)), bank_t'(wa[`BANK_BITS-1:0] + bank_t'(1 + {$random(seed)} % 3))};
      step(1'b1, ra, 1'b1, wa, wd);
      step(1'b1, wa, 1'b0, '0, '0);
    end
    idle();
    end_test("no collision");

    for (int i = 0; i < N_COLL; i++) begin
      wa = addr_t'($random(seed));
      wd = data_t'($random(seed));
      ra = {row_t'(wa[`ADDR_BITS-1:`BANK_BITS] + row_t'(1 + {$random(seed)} % 15)),
            wa[`BANK_BITS-1:0]};
      step(1'b1, ra, 1'b1, wa, wd);
      step(1'b1, wa, 1'b0, '0, '0);
    end
    idle();
    end_test("collision to spare");

    // two rows over all banks keep the spare busy
    for (int i = 0; i < N_RAND; i++) begin
      ra = {row_t'({$random(seed)} % 2), bank_t'($random(seed))};
      wa = {row_t'({$random(seed)} % 2), bank_t'($random(seed))};
      wd = data_t'($random(seed));
      step(({$random(seed)} % 8) != 0, ra, ({$random(seed)} % 8) != 0, wa, wd);
    end
    idle();
    if (ev_count == 0) begin
      $display("random traffic caused no eviction");
      errors++;
    end
    end_test("random traffic with evictions");

    for (int i = 0; i < N_SAME; i++) begin
      wa = addr_t'($random(seed));
      step(1'b0, '0, 1'b1, wa, data_t'($random(seed)));
      step(1'b1, wa, 1'b1, wa, data_t'($random(seed)));
      step(1'b1, wa, 1'b0, '0, '0);
    end
    idle();
    end_test("read and write same address");

    for (int i = 0; i < N_B2B; i++) begin
      ra = {row_t'({$random(seed)} % 2), bank_t'($random(seed))};
      step(1'b1, ra, 1'b0, '0, '0);
    end
    idle();
    end_test("back-to-back reads");

    $display("tests %0d, checks %0d, errors %0d", test_num, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+include
rtl/mem_pkg.sv
rtl/bank_ram.sv
rtl/spare_ram.sv
rtl/map_table.sv
rtl/remap_ctrl.sv
rtl/mem_1r1w_top.sv
verification/tb_mem_1r1w.sv

//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing -f project.f --top-module tb_mem_1r1w -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/Vtb_mem_1r1w)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
